// File: eth_pkg.sv
/* Ethernet/IPv4/UDP protocol constants, header byte offsets,
   and the beat and header-flag structs of the receive stream */
package eth_pkg;

  // ----------------------------
  // beat geometry
  // ----------------------------
  localparam int ENET_W         = 64;
  localparam int BYTES_PER_BEAT = 8;
  // trailing byte count, 0 means all eight valid
  localparam int TRAIL_W        = 3;

  // ----------------------------
  // header byte offsets from frame start
  // ----------------------------
  localparam int DST_MAC_BYTE  = 0;
  localparam int ETH_TYPE_BYTE = 12;
  localparam int PROTOCOL_BYTE = 23;
  localparam int DST_IP_BYTE   = 30;
  localparam int DST_PORT_BYTE = 36;
  // beat holding byte 37, last byte of the udp dst port
  localparam int HEADER_LAST_BEAT = 4;

  // protocol values
  localparam logic [47:0] ETH_ADDR_BCAST = 48'hFFFF_FFFF_FFFF;
  localparam logic [15:0] ETH_TYPE_IPV4  = 16'h0800;
  localparam logic [7:0]  IPV4_PROTO_UDP = 8'd17;

  // beat as delivered by the mac, error travels on its own port
  typedef struct packed {
    logic [ENET_W-1:0]  data;
    logic [TRAIL_W-1:0] trailing;
    logic               last;
  } eth_rx_beat_t;

  // beat inside the design and on the outputs
  typedef struct packed {
    logic [ENET_W-1:0]  data;
    logic [TRAIL_W-1:0] trailing;
    logic               last;
  } eth_beat_t;

  // header decode results, valid with the header-done beat
  typedef struct packed {
    logic is_broadcast;
    logic is_ipv4;
    logic is_udp;
    logic ip_and_port_match;
  } header_flags_t;

endpackage

// File: dispatch_pkg.sv
/* routing and classifier state encodings, gate write struct
   and packet buffer depth for the receive dispatcher */
package dispatch_pkg;

  // ----------------------------
  // routing decision
  // ----------------------------
  typedef enum logic [1:0] {
    ROUTE_NONE = 2'd0,
    ROUTE_CHDR = 2'd1,
    ROUTE_CPU  = 2'd2
  } route_t;

  // classifier fsm
  typedef enum logic [1:0] {
    ST_HEADER    = 2'd0,
    ST_FWD_CHDR  = 2'd1,
    ST_FWD_CPU   = 2'd2,
    ST_DROP_WAIT = 2'd3
  } classify_state_t;

  // one write into a packet gate
  // abort set means discard the frame in progress, beat not stored
  typedef struct packed {
    eth_pkg::eth_beat_t beat;
    logic               write;
    logic               abort;
  } gate_write_t;

  // words per gate, five 100-beat frames fit
  localparam int GATE_DEPTH_WORDS = 512;

endpackage

// File: eth_header_parser.sv
/* input stage that registers rx beats, captures eth/ipv4/udp header
   fields and produces the match flags for the classifier */
`timescale 1ns/10ps

module eth_header_parser
  import eth_pkg::*;
(
  input  logic          clk_eth_rx,
  input  logic          reset,
  input  logic          rx_valid,
  input  eth_rx_beat_t  rx_beat,
  input  logic          rx_error,
  input  logic [31:0]   my_ip,
  input  logic [15:0]   my_udp_chdr_port,
  output logic          p_valid,
  output eth_beat_t     p_beat,
  output logic          p_error,
  output logic          p_header_done,
  output header_flags_t p_flags
);

  // beat index in the frame that saturates past the header
  logic [2:0]  beat_cnt;
  logic        at_hdr_end;

  // captured fields and the same fields merged with the live beat
  logic [47:0] mac_q, mac_new;
  logic [15:0] type_q, type_new;
  logic [7:0]  proto_q, proto_new;
  logic [31:0] ip_q, ip_new;
  logic [15:0] port_q, port_new;

  // overlay the bytes of one field that sit in the current beat
  // field is right aligned with the first byte most significant
  function automatic logic [47:0] merge_field(
    input logic [47:0]       old_val,
    input int                first_byte,
    input int                num_bytes,
    input logic [2:0]        beat_idx,
    input logic [ENET_W-1:0] data
  );
    logic [47:0] val;
    int          pos;
    val = old_val;
    for (int i = 0; i < 6; i++) begin
      pos = first_byte + i;
      if (i < num_bytes) begin
        if (beat_idx == pos / BYTES_PER_BEAT) begin
          val[8*(num_bytes-1-i) +: 8] = data[8*(pos % BYTES_PER_BEAT) +: 8];
        end
      end
    end
    return val;
  endfunction

  assign at_hdr_end = (beat_cnt == 3'(HEADER_LAST_BEAT));

  always_comb begin
    mac_new   = merge_field(mac_q, DST_MAC_BYTE, 6, beat_cnt, rx_beat.data);
    type_new  = 16'(merge_field(48'(type_q), ETH_TYPE_BYTE, 2, beat_cnt, rx_beat.data));
    proto_new = 8'(merge_field(48'(proto_q), PROTOCOL_BYTE, 1, beat_cnt, rx_beat.data));
    ip_new    = 32'(merge_field(48'(ip_q), DST_IP_BYTE, 4, beat_cnt, rx_beat.data));
    port_new  = 16'(merge_field(48'(port_q), DST_PORT_BYTE, 2, beat_cnt, rx_beat.data));
  end

  // ----------------------------
  // beat counter and control
  // ----------------------------
  always_ff @(posedge clk_eth_rx) begin
    if (reset) begin
      beat_cnt      <= '0;
      p_valid       <= 1'b0;
      p_error       <= 1'b0;
      p_header_done <= 1'b0;
    end else begin
      p_valid       <= rx_valid;
      p_error       <= rx_valid && rx_error;
      p_header_done <= rx_valid && at_hdr_end;
      if (rx_valid) begin
        if (rx_beat.last) begin
          beat_cnt <= '0;
        end else if (beat_cnt != 3'd7) begin
          beat_cnt <= beat_cnt + 3'd1;
        end
      end
    end
  end

  // ----------------------------
  // payload and header capture
  // ----------------------------
  always_ff @(posedge clk_eth_rx) begin
    if (rx_valid) begin
      p_beat.data     <= rx_beat.data;
      p_beat.trailing <= rx_beat.trailing;
      p_beat.last     <= rx_beat.last;
      mac_q           <= mac_new;
      type_q          <= type_new;
      proto_q         <= proto_new;
      ip_q            <= ip_new;
      port_q          <= port_new;
    end
    // flags from the last header beat in step with p_header_done
    if (rx_valid && at_hdr_end) begin
      p_flags.is_broadcast      <= (mac_new == ETH_ADDR_BCAST);
      p_flags.is_ipv4           <= (type_new == ETH_TYPE_IPV4);
      p_flags.is_udp            <= (proto_new == IPV4_PROTO_UDP);
      p_flags.ip_and_port_match <= (ip_new == my_ip) &&
                                   (port_new == my_udp_chdr_port);
    end
  end

  // header done marks one real beat per header
  a_hdr_done_valid : assert property (
    @(posedge clk_eth_rx) disable iff (reset)
      p_header_done |-> p_valid && !$past(p_header_done)
  );

endmodule

// File: dispatch_classifier.sv
/* classifier fsm: writes each frame to both packet gates until the
   header is decoded, then keeps one gate and aborts the other */
`timescale 1ns/10ps

module dispatch_classifier
  import eth_pkg::*;
  import dispatch_pkg::*;
(
  input  logic            clk_eth_rx,
  input  logic            reset,
  input  logic            p_valid,
  input  eth_beat_t       p_beat,
  input  logic            p_error,
  input  logic            p_header_done,
  input  header_flags_t   p_flags,
  output gate_write_t     chdr_wr,
  output gate_write_t     cpu_wr
);

  classify_state_t state, state_nxt;
  route_t          route;
  logic            decided;
  logic            chdr_we, chdr_ab, cpu_we, cpu_ab;
  logic            chdr_commit, cpu_commit;

  // ----------------------------
  // route decision
  // ----------------------------
  always_comb begin
    route = ROUTE_NONE;
    if (!p_error) begin
      if (p_header_done) begin
        // broadcast wins over a chdr match
        if (!p_flags.is_broadcast && p_flags.is_ipv4 && p_flags.is_udp &&
            p_flags.ip_and_port_match) begin
          route = ROUTE_CHDR;
        end else begin
          route = ROUTE_CPU;
        end
      end else if (p_beat.last) begin
        // frame ended inside the header
        route = ROUTE_CPU;
      end
    end
    decided = p_error || p_header_done || p_beat.last;
  end

  // next state and gate write strobes
  always_comb begin
    state_nxt = state;
    chdr_we   = 1'b0;
    chdr_ab   = 1'b0;
    cpu_we    = 1'b0;
    cpu_ab    = 1'b0;
    if (p_valid) begin
      case (state)
        ST_HEADER: begin
          // both gates hold the frame until the route is known
          chdr_we = 1'b1;
          cpu_we  = 1'b1;
          if (decided) begin
            chdr_ab = (route != ROUTE_CHDR);
            cpu_ab  = (route != ROUTE_CPU);
            case (route)
              ROUTE_CHDR: state_nxt = ST_FWD_CHDR;
              ROUTE_CPU:  state_nxt = ST_FWD_CPU;
              default:    state_nxt = ST_DROP_WAIT;
            endcase
          end
        end
        ST_FWD_CHDR: begin
          chdr_we = 1'b1;
          chdr_ab = p_error;
          if (p_error) state_nxt = ST_DROP_WAIT;
        end
        ST_FWD_CPU: begin
          cpu_we = 1'b1;
          cpu_ab = p_error;
          if (p_error) state_nxt = ST_DROP_WAIT;
        end
        default: begin
          // drop wait, swallow beats until last
        end
      endcase
      // every frame restarts in header state
      if (p_beat.last) state_nxt = ST_HEADER;
    end
  end

  // ----------------------------
  // registered gate writes
  // ----------------------------
  always_ff @(posedge clk_eth_rx) begin
    chdr_wr.beat <= p_beat;
    cpu_wr.beat  <= p_beat;
    if (reset) begin
      state         <= ST_HEADER;
      chdr_wr.write <= 1'b0;
      chdr_wr.abort <= 1'b0;
      cpu_wr.write  <= 1'b0;
      cpu_wr.abort  <= 1'b0;
    end else begin
      state         <= state_nxt;
      chdr_wr.write <= chdr_we;
      chdr_wr.abort <= chdr_ab;
      cpu_wr.write  <= cpu_we;
      cpu_wr.abort  <= cpu_ab;
    end
  end

  assign chdr_commit = chdr_wr.write && !chdr_wr.abort && chdr_wr.beat.last;
  assign cpu_commit  = cpu_wr.write && !cpu_wr.abort && cpu_wr.beat.last;

  // a frame lands in one gate at most
  a_single_commit : assert property (
    @(posedge clk_eth_rx) disable iff (reset) !(chdr_commit && cpu_commit)
  );

endmodule

// File: packet_gate.sv
/* packet gate: circular frame buffer that releases a frame after its
   last beat and rewinds on abort or overflow */
`timescale 1ns/10ps

module packet_gate
  import eth_pkg::*;
  import dispatch_pkg::*;
#(
  parameter int DEPTH = 512
) (
  input  logic        clk_eth_rx,
  input  logic        reset,
  input  gate_write_t wr,
  output logic        out_valid,
  output eth_beat_t   out_beat,
  input  logic        out_ready,
  output logic        dropped
);

  localparam int AW = $clog2(DEPTH);

  eth_beat_t   mem [DEPTH];

  // pointers carry one wrap bit
  logic [AW:0] wr_ptr, commit_ptr, rd_ptr;
  logic [AW:0] occupancy;
  logic        full;
  // current frame lost room, its remaining beats are ignored
  logic        overflow;
  logic        store;
  logic        rewind;
  logic        pop;

  assign occupancy = wr_ptr - rd_ptr;
  assign full      = (occupancy == (AW+1)'(DEPTH));

  // real beat that still fits
  assign store  = wr.write && !wr.abort && !overflow && !full;
  // abort, or frame end after the buffer ran out
  assign rewind = wr.write && (wr.abort || (wr.beat.last && (overflow || full)));

  // ----------------------------
  // write side
  // ----------------------------
  always_ff @(posedge clk_eth_rx) begin
    if (store) begin
      mem[wr_ptr[AW-1:0]] <= wr.beat;
    end
  end

  always_ff @(posedge clk_eth_rx) begin
    if (reset) begin
      wr_ptr     <= '0;
      commit_ptr <= '0;
      overflow   <= 1'b0;
      dropped    <= 1'b0;
    end else begin
      dropped <= 1'b0;
      if (rewind) begin
        wr_ptr   <= commit_ptr;
        overflow <= 1'b0;
        // pulse only when the buffer was the reason
        dropped  <= overflow || (!wr.abort && full);
      end else if (store) begin
        wr_ptr <= wr_ptr + 1'b1;
        if (wr.beat.last) commit_ptr <= wr_ptr + 1'b1;
      end else if (wr.write) begin
        overflow <= 1'b1;
      end
    end
  end

  // ----------------------------
  // read side
  // ----------------------------
  // committed words only, first word falls through
  assign out_valid = (rd_ptr != commit_ptr);
  assign out_beat  = mem[rd_ptr[AW-1:0]];
  assign pop       = out_valid && out_ready;

  always_ff @(posedge clk_eth_rx) begin
    if (reset) begin
      rd_ptr <= '0;
    end else if (pop) begin
      rd_ptr <= rd_ptr + 1'b1;
    end
  end

  // writer never laps the reader
  a_occupancy : assert property (
    @(posedge clk_eth_rx) disable iff (reset) occupancy <= (AW+1)'(DEPTH)
  );

  // held beat does not move under back-pressure
  a_stall_stable : assert property (
    @(posedge clk_eth_rx) disable iff (reset)
      out_valid && !out_ready |=> out_valid && $stable(out_beat)
  );

endmodule

// File: eth_chdr_dispatch.sv
/* ethernet rx dispatcher top: header parser, classifier and the
   chdr and cpu packet gates */
`timescale 1ns/10ps

module eth_chdr_dispatch
  import eth_pkg::*;
  import dispatch_pkg::*;
(
  input  logic         clk_eth_rx,
  input  logic         reset,
  input  logic         rx_valid,
  input  eth_rx_beat_t rx_beat,
  input  logic         rx_error,
  // static addresses, mac kept for the system interface only
  input  logic [47:0]  my_mac,
  input  logic [31:0]  my_ip,
  input  logic [15:0]  my_udp_chdr_port,
  output logic         e2v_valid,
  output eth_beat_t    e2v_beat,
  input  logic         e2v_ready,
  output logic         e2c_valid,
  output eth_beat_t    e2c_beat,
  input  logic         e2c_ready,
  output logic         chdr_dropped,
  output logic         cpu_dropped
);

  // ----------------------------
  // parser to classifier
  // ----------------------------
  logic          p_valid;
  eth_beat_t     p_beat;
  logic          p_error;
  logic          p_header_done;
  header_flags_t p_flags;

  // classifier to gates
  gate_write_t   chdr_wr;
  gate_write_t   cpu_wr;

  eth_header_parser i_parser (
    .clk_eth_rx       (clk_eth_rx),
    .reset            (reset),
    .rx_valid         (rx_valid),
    .rx_beat          (rx_beat),
    .rx_error         (rx_error),
    .my_ip            (my_ip),
    .my_udp_chdr_port (my_udp_chdr_port),
    .p_valid          (p_valid),
    .p_beat           (p_beat),
    .p_error          (p_error),
    .p_header_done    (p_header_done),
    .p_flags          (p_flags)
  );

  dispatch_classifier i_classifier (
    .clk_eth_rx    (clk_eth_rx),
    .reset         (reset),
    .p_valid       (p_valid),
    .p_beat        (p_beat),
    .p_error       (p_error),
    .p_header_done (p_header_done),
    .p_flags       (p_flags),
    .chdr_wr       (chdr_wr),
    .cpu_wr        (cpu_wr)
  );

  // chdr path to e2v
  packet_gate #(.DEPTH(GATE_DEPTH_WORDS)) i_chdr_gate (
    .clk_eth_rx (clk_eth_rx),
    .reset      (reset),
    .wr         (chdr_wr),
    .out_valid  (e2v_valid),
    .out_beat   (e2v_beat),
    .out_ready  (e2v_ready),
    .dropped    (chdr_dropped)
  );

  // cpu path to e2c
  packet_gate #(.DEPTH(GATE_DEPTH_WORDS)) i_cpu_gate (
    .clk_eth_rx (clk_eth_rx),
    .reset      (reset),
    .wr         (cpu_wr),
    .out_valid  (e2c_valid),
    .out_beat   (e2c_beat),
    .out_ready  (e2c_ready),
    .dropped    (cpu_dropped)
  );

endmodule

// File: tb_eth_chdr_dispatch.sv
/* testbench for the rx dispatcher: frame builder, per-output expected
   beat queues, directed tests and a watchdog */
`timescale 1ns/10ps

module tb_eth_chdr_dispatch
  import eth_pkg::*;
;

  localparam int RAND_SEED = 32'h91905f12;
  localparam logic [47:0] MY_MAC  = 48'h0211_2233_4455;
  localparam logic [31:0] MY_IP   = 32'hC0A8_0A02;
  localparam logic [15:0] MY_PORT = 16'd49153;
  // frame sizes in bytes: 10, 8, 3 and 100 beats
  localparam int STD_BYTES = 76;
  localparam int ERR_BYTES = 64;
  localparam int SHORT_BYTES = 20;
  localparam int BIG_BYTES = 797;
  // beats sent over all tests, sets the watchdog limit
  localparam int TOTAL_BEATS = 10 + 10 + 3 * 10 + 8 + 10 + 3 + 7 * 100;
  localparam int WATCHDOG_NS = TOTAL_BEATS * 4 * 4 + 2000;
  localparam int TO_NONE = 0;
  localparam int TO_CHDR = 1;
  localparam int TO_CPU = 2;

  logic clk_eth_rx, reset, rx_valid, rx_error, e2v_ready, e2c_ready;
  logic e2v_valid, e2c_valid, chdr_dropped, cpu_dropped;
  logic [47:0] my_mac;
  logic [31:0] my_ip;
  logic [15:0] my_udp_chdr_port;
  eth_rx_beat_t rx_beat;
  eth_beat_t e2v_beat, e2c_beat;

  // expected beats per output, filled by the frame builder
  eth_beat_t chdr_q[$];
  eth_beat_t cpu_q[$];
  eth_beat_t exp_v, exp_c, held_beat;
  int avail_v, avail_c;
  logic [7:0] fb [0:1023];
  string test_name = "reset";
  int err_cnt = 0, err_start = 0, check_cnt = 0, test_cnt = 0;
  int chdr_drop_cnt = 0, cpu_drop_cnt = 0;
  bit jitter = 1'b0;
  bit stalled = 1'b0;

  eth_chdr_dispatch i_dut (.*);

  initial begin
    clk_eth_rx = 1'b0;
    forever #2 clk_eth_rx = ~clk_eth_rx;
  end

  // ------------------------------
  // output checking
  // ------------------------------
  task automatic compare_beat(input string port, input int avail, input eth_beat_t exp,
                              input eth_beat_t act);
    check_cnt++;
    assert (avail > 0) else begin
      $display("%s: beat on %s while nothing was expected", test_name, port);
      err_cnt++;
    end
    if (avail > 0) begin
      assert (act == exp) else begin
        $display("ERR %s %s expected %h actual %h", test_name, port, exp, act);
        err_cnt++;
      end
    end
  endtask

  always @(posedge clk_eth_rx) begin
    if (!reset && e2v_valid && e2v_ready) begin
      exp_v = '0;
      avail_v = chdr_q.size();
      if (avail_v > 0) exp_v = chdr_q.pop_front();
      compare_beat("e2v", avail_v, exp_v, e2v_beat);
    end
    if (!reset && e2c_valid && e2c_ready) begin
      exp_c = '0;
      avail_c = cpu_q.size();
      if (avail_c > 0) exp_c = cpu_q.pop_front();
      compare_beat("e2c", avail_c, exp_c, e2c_beat);
    end
    if (!reset && chdr_dropped) chdr_drop_cnt++;
    if (!reset && cpu_dropped) cpu_drop_cnt++;
  end

  // e2v beat must hold while stalled
  always @(posedge clk_eth_rx) begin
    if (!reset && stalled) begin
      assert (e2v_valid && e2v_beat == held_beat) else begin
        $display("%s: e2v beat changed or vanished while stalled", test_name);
        err_cnt++;
      end
    end
    stalled = !reset && e2v_valid && !e2v_ready;
    held_beat = e2v_beat;
  end

  // ------------------------------
  // stimulus helpers
  // ------------------------------
  task automatic tick;
    @(posedge clk_eth_rx);
    if (jitter) e2v_ready <= 1'($urandom_range(1, 0));
  endtask

  task automatic put_field(input int offset, input logic [47:0] value, input int n);
    for (int i = 0; i < n; i++) fb[offset + i] = value[8 * (n - 1 - i) +: 8];
  endtask

  // routing rule: error, short header, broadcast, chdr match, else cpu
  function automatic int expected_route(input logic [47:0] dst_mac,
      input logic [15:0] eth_type, input logic [7:0] proto, input logic [31:0] dst_ip,
      input logic [15:0] dst_port, input int nbytes, input bit err);
    if (err) return TO_NONE;
    if (nbytes < DST_PORT_BYTE + 2) return TO_CPU;
    if (dst_mac == ETH_ADDR_BCAST) return TO_CPU;
    if (eth_type == ETH_TYPE_IPV4 && proto == IPV4_PROTO_UDP && dst_ip == MY_IP &&
        dst_port == MY_PORT) return TO_CHDR;
    return TO_CPU;
  endfunction

  // builds one frame, queues its expected beats and drives it back to back
  task automatic send_frame(input logic [47:0] dst_mac, input logic [15:0] eth_type,
      input logic [7:0] proto, input logic [31:0] dst_ip, input logic [15:0] dst_port,
      input int nbytes, input bit err, input bit fits);
    int nbeats;
    int dest;
    eth_beat_t b;
    nbeats = (nbytes + BYTES_PER_BEAT - 1) / BYTES_PER_BEAT;
    for (int k = 0; k < nbeats * BYTES_PER_BEAT; k++) fb[k] = 8'($urandom);
    put_field(DST_MAC_BYTE, dst_mac, 6);
    put_field(6, 48'h0200_0000_0001, 6);
    put_field(ETH_TYPE_BYTE, {32'd0, eth_type}, 2);
    // version 4, 20-byte ip header
    fb[14] = 8'h45;
    put_field(PROTOCOL_BYTE, {40'd0, proto}, 1);
    put_field(DST_IP_BYTE, {16'd0, dst_ip}, 4);
    put_field(DST_PORT_BYTE, {32'd0, dst_port}, 2);
    dest = expected_route(dst_mac, eth_type, proto, dst_ip, dst_port, nbytes, err);
    if (!fits) dest = TO_NONE;
    for (int n = 0; n < nbeats; n++) begin
      for (int j = 0; j < BYTES_PER_BEAT; j++) b.data[8 * j +: 8] = fb[8 * n + j];
      b.last = (n == nbeats - 1);
      b.trailing = b.last ? TRAIL_W'(nbytes % BYTES_PER_BEAT) : '0;
      if (dest == TO_CHDR) chdr_q.push_back(b);
      else if (dest == TO_CPU) cpu_q.push_back(b);
      tick();
      rx_valid <= 1'b1;
      rx_beat <= eth_rx_beat_t'(b);
      rx_error <= err && b.last;
    end
  endtask

  // input idle, then both outputs drained of everything expected
  task automatic wait_idle;
    tick();
    rx_valid <= 1'b0;
    rx_error <= 1'b0;
    repeat (5) tick();
    while (chdr_q.size() > 0 || cpu_q.size() > 0 || e2v_valid || e2c_valid) tick();
  endtask

  task automatic begin_test(input string name);
    test_name = name;
    err_start = err_cnt;
  endtask

  task automatic finish_test;
    $display("test %-12s done, %0d errors", test_name, err_cnt - err_start);
    test_cnt++;
  endtask

  // ------------------------------
  // directed tests
  // ------------------------------
  task automatic test_chdr_match;
    begin_test("chdr_match");
    send_frame(MY_MAC, ETH_TYPE_IPV4, IPV4_PROTO_UDP, MY_IP, MY_PORT, STD_BYTES, 0, 1);
    wait_idle();
    finish_test();
  endtask

  task automatic test_broadcast;
    begin_test("broadcast");
    send_frame(ETH_ADDR_BCAST, ETH_TYPE_IPV4, IPV4_PROTO_UDP, MY_IP, MY_PORT,
               STD_BYTES, 0, 1);
    wait_idle();
    finish_test();
  endtask

  task automatic test_cpu_misses;
    begin_test("cpu_misses");
    send_frame(MY_MAC, ETH_TYPE_IPV4, IPV4_PROTO_UDP, MY_IP, MY_PORT + 16'd1,
               STD_BYTES, 0, 1);
    send_frame(MY_MAC, ETH_TYPE_IPV4, IPV4_PROTO_UDP, MY_IP ^ 32'h1, MY_PORT, STD_BYTES, 0, 1);
    // ipv6 ethertype
    send_frame(MY_MAC, 16'h86DD, IPV4_PROTO_UDP, MY_IP, MY_PORT, STD_BYTES, 0, 1);
    wait_idle();
    finish_test();
  endtask

  task automatic test_error_drop;
    begin_test("error_drop");
    send_frame(MY_MAC, ETH_TYPE_IPV4, IPV4_PROTO_UDP, MY_IP, MY_PORT, ERR_BYTES, 1, 1);
    send_frame(MY_MAC, ETH_TYPE_IPV4, IPV4_PROTO_UDP, MY_IP, MY_PORT, STD_BYTES, 0, 1);
    wait_idle();
    finish_test();
  endtask

  task automatic test_short_frame;
    begin_test("short_frame");
    send_frame(MY_MAC, ETH_TYPE_IPV4, IPV4_PROTO_UDP, MY_IP, MY_PORT, SHORT_BYTES, 0, 1);
    wait_idle();
    finish_test();
  endtask

  // five 100-beat frames fill the 512-word gate, the sixth overflows
  task automatic test_overflow;
    int drops_before;
    begin_test("overflow");
    drops_before = chdr_drop_cnt;
    tick();
    e2v_ready <= 1'b0;
    for (int i = 0; i < 6; i++) begin
      send_frame(MY_MAC, ETH_TYPE_IPV4, IPV4_PROTO_UDP, MY_IP, MY_PORT, BIG_BYTES, 0, i < 5);
    end
    tick();
    rx_valid <= 1'b0;
    repeat (8) tick();
    assert (chdr_drop_cnt - drops_before == 1) else begin
      $display("ERR %s chdr_dropped pulses expected 1 actual %0d", test_name,
               chdr_drop_cnt - drops_before);
      err_cnt++;
    end
    assert (cpu_drop_cnt == 0) else begin
      $display("ERR %s cpu_dropped pulses expected 0 actual %0d", test_name, cpu_drop_cnt);
      err_cnt++;
    end
    e2v_ready <= 1'b1;
    wait_idle();
    // one more frame with e2v_ready toggling at random
    jitter = 1'b1;
    send_frame(MY_MAC, ETH_TYPE_IPV4, IPV4_PROTO_UDP, MY_IP, MY_PORT, BIG_BYTES, 0, 1);
    wait_idle();
    jitter = 1'b0;
    tick();
    e2v_ready <= 1'b1;
    finish_test();
  endtask

  initial begin
    void'($urandom(RAND_SEED));
    reset = 1'b1;
    rx_valid = 1'b0;
    rx_beat = '0;
    rx_error = 1'b0;
    e2v_ready = 1'b1;
    e2c_ready = 1'b1;
    my_mac = MY_MAC;
    my_ip = MY_IP;
    my_udp_chdr_port = MY_PORT;
    repeat (8) @(posedge clk_eth_rx);
    reset <= 1'b0;
    test_chdr_match();
    test_broadcast();
    test_cpu_misses();
    test_error_drop();
    test_short_frame();
    test_overflow();
    $display("tests %0d, checks %0d, errors %0d", test_cnt, check_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

  // watchdog, scaled from the beats sent over all tests
  initial begin
    #(WATCHDOG_NS);
    $display("timeout: tests still running after %0d ns in %s", WATCHDOG_NS, test_name);
    $display("Something failed");
    $finish;
  end

endmodule

// File: eth_chdr_dispatch.f
eth_pkg.sv
dispatch_pkg.sv
eth_header_parser.sv
dispatch_classifier.sv
packet_gate.sv
eth_chdr_dispatch.sv
tb_eth_chdr_dispatch.sv

// File: run_sim.sh
#!/bin/sh
# compile the dispatcher testbench with verilator and run it
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_eth_chdr_dispatch -f eth_chdr_dispatch.f -o sim_tb
out=$(./obj_dir/sim_tb)
echo "$out"
if echo "$out" | grep -qx "Everything OK"; then
  exit 0
fi
exit 1
